//--- vlog.f
hw/fildown_pkg.sv
hw/coeff_store.sv
hw/sample_window.sv
hw/tap_sequencer.sv
hw/mac_stage.sv
hw/round_saturate.sv
hw/fildown_top.sv
bench/clock_gen.sv
bench/tb_fildown.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fildown \
	-f vlog.f -o tb_fildown_sim \
	&& ./obj_dir/tb_fildown_sim 2>&1 | tee sim.log
grep -qx "TEST PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- bench/tb_fildown.sv
// Default filter shape only, and results whose window reaches back before a reset are not compared
`default_nettype none
`timescale 1ns/1ps

module tb_fildown;
	import fildown_pkg::*;

	// Filter shape as built by the DUT defaults
	localparam int NDOWN = DEF_NDOWN;
	localparam int NCOEFFS = DEF_NCOEFFS;
	localparam int SHIFT = DEF_SHIFT;
	// Rounding point inside the accumulator
	localparam int TW = (NCOEFFS > 1) ? $clog2(NCOEFFS) : 1;
	localparam int AW = IW + CW + TW;
	localparam int FRAC = AW - SHIFT - OW;
	localparam longint OMAX = (longint'(1) <<< (OW - 1)) - 1;
	localparam longint OMIN = -(longint'(1) <<< (OW - 1));
	// Negedges from the trigger sample to its o_valid pulse
	localparam int LATENCY = NCOEFFS + 4;
	// Full scale words
	localparam logic [IW-1:0] SMAX = {1'b0, {(IW-1){1'b1}}};
	localparam logic [IW-1:0] SMIN = {1'b1, {(IW-1){1'b0}}};
	localparam logic [CW-1:0] CMIN = {1'b1, {(CW-1){1'b0}}};
	localparam logic [IW-1:0] IMPULSE = IW'(1 << (IW - 2));
	// Samples sent by each test
	localparam int N_IMPULSE = 3 * NCOEFFS + 1;
	localparam int N_STREAM = 200;
	localparam int N_BURST = 200;
	localparam int SAT_BLOCK = NCOEFFS + NDOWN + 4;
	localparam int N_SAT = 6 * SAT_BLOCK;
	localparam int N_WRAP = 120;
	localparam int N_TOTAL = N_IMPULSE + N_STREAM + N_BURST + N_SAT + N_WRAP;
	localparam longint WATCHDOG_NS = longint'(2 * N_TOTAL * (NCOEFFS + 8) * 40);
	localparam int SEED = 32'h8b29;

	logic i_clk;
	logic i_reset;
	logic i_valid;
	logic [IW-1:0] i_sample;
	logic o_ready;
	logic i_wr_coeff;
	logic [CW-1:0] i_coeff;
	logic o_valid;
	logic [OW-1:0] o_result;

	////////////////////////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////////////////////////

	// Taps with their own wrapping write pointer
	int coeff_model [NCOEFFS];
	int coeff_ptr = 0;
	// Every sample accepted since the last reset, oldest first
	int sample_hist [$];
	// Pending results, whether to compare them, and their due negedge
	logic [OW-1:0] exp_q [$];
	bit skip_q [$];
	int due_q [$];
	// Negedges left in which the sequencer is still walking taps
	int busy_left = 0;
	int neg_cycle = 0;
	int reset_seen = 0;
	int n_triggers = 0;
	int n_outputs = 0;
	int n_stalls = 0;
	int n_sat_hi = 0;
	int n_sat_lo = 0;

	clock_gen #(.PERIOD_NS(40)) clock_gen_inst (.o_clk(i_clk));

	fildown_top fildown_top_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid(i_valid), .i_sample(i_sample), .o_ready(o_ready),
		.i_wr_coeff(i_wr_coeff), .i_coeff(i_coeff),
		.o_valid(o_valid), .o_result(o_result)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("CHECK FAILED %s got 0x%h expected 0x%h",
				name, actual, expected));
	endtask

	// Shift, round half to even, then clamp to the output range
	function automatic logic [OW-1:0] expected_word(input longint acc);
		longint q;
		longint rem;
		longint half;
		q = acc >>> FRAC;
		rem = acc - (q <<< FRAC);
		half = longint'(1) <<< (FRAC - 1);
		if ((rem > half) || ((rem == half) && ((q % 2) != 0)))
			q = q + 1;
		if (q > OMAX)
			q = OMAX;
		else if (q < OMIN)
			q = OMIN;
		return q[OW-1:0];
	endfunction

	// Every NDOWN-th accepted sample queues one result
	task automatic accept_sample(input int value);
		int m;
		int k;
		longint acc;
		m = sample_hist.size();
		sample_hist.push_back(value);
		if ((m % NDOWN) == NDOWN - 1)
		begin
			n_triggers++;
			busy_left = NCOEFFS;
			due_q.push_back(neg_cycle + LATENCY);
			// Window reaches into memory never written since reset
			if (m < NCOEFFS - 1)
			begin
				skip_q.push_back(1'b1);
				exp_q.push_back('0);
			end
			else
			begin
				acc = 0;
				for (k = 0; k < NCOEFFS; k++)
					acc += longint'(coeff_model[k]) * longint'(sample_hist[m - k]);
				skip_q.push_back(1'b0);
				exp_q.push_back(expected_word(acc));
			end
		end
	endtask

	task automatic check_output;
		logic [OW-1:0] expected;
		bit skip;
		int due;
		if (exp_q.size() == 0)
			stop_with_failure("o_valid pulsed while no result was expected");
		else
		begin
			expected = exp_q.pop_front();
			skip = skip_q.pop_front();
			due = due_q.pop_front();
			n_outputs++;
			check_value("o_valid cycle", 32'(neg_cycle), 32'(due));
			if (!skip)
			begin
				check_value("o_result", 32'(o_result), 32'(expected));
				if (longint'($signed(expected)) == OMAX)
					n_sat_hi++;
				if (longint'($signed(expected)) == OMIN)
					n_sat_lo++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Monitor, samples at the falling edge where all is stable
	////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		logic ready_exp;
		if (i_reset !== 1'b0)
		begin
			// Registers are cleared from the first reset edge on
			if (reset_seen > 0)
			begin
				check_value("o_valid", 32'(o_valid), 32'd0);
				check_value("o_ready", 32'(o_ready), 32'd1);
			end
			reset_seen++;
			sample_hist.delete();
			exp_q.delete();
			skip_q.delete();
			due_q.delete();
			coeff_ptr = 0;
			busy_left = 0;
		end
		else
		begin
			reset_seen = 0;
			neg_cycle++;
			if (o_valid)
				check_output();
			// Only a trigger sample is held off, and only while taps are walked
			ready_exp = !((busy_left > 0) && ((sample_hist.size() % NDOWN) == NDOWN - 1));
			check_value("o_ready", 32'(o_ready), 32'(ready_exp));
			if (busy_left > 0)
				busy_left--;
			if (i_wr_coeff)
			begin
				coeff_model[coeff_ptr] = int'($signed(i_coeff));
				coeff_ptr = (coeff_ptr == NCOEFFS - 1) ? 0 : coeff_ptr + 1;
			end
			if (i_valid && !o_ready)
				n_stalls++;
			else if (i_valid)
				accept_sample(int'($signed(i_sample)));
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic apply_reset;
		i_reset <= 1'b1;
		i_valid <= 1'b0;
		i_wr_coeff <= 1'b0;
		repeat (16) @(posedge i_clk);
		i_reset <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		i_valid <= 1'b0;
		i_wr_coeff <= 1'b0;
		repeat (n) @(posedge i_clk);
	endtask

	// Holds the sample until the DUT takes it
	task automatic send_sample(input logic [IW-1:0] value);
		i_valid <= 1'b1;
		i_sample <= value;
		@(negedge i_clk);
		while (!o_ready)
			@(negedge i_clk);
		@(posedge i_clk);
	endtask

	task automatic write_coeff(input logic [CW-1:0] value);
		i_valid <= 1'b0;
		i_wr_coeff <= 1'b1;
		i_coeff <= value;
		@(posedge i_clk);
	endtask

	task automatic load_random_coeffs(input int count);
		int k;
		for (k = 0; k < count; k++)
			write_coeff(CW'($urandom));
		i_wr_coeff <= 1'b0;
	endtask

	// Lets every pending run finish before taps change
	task automatic drain_results;
		int waited;
		i_valid <= 1'b0;
		waited = 0;
		while ((exp_q.size() != 0) && (waited < 2 * (NCOEFFS + 8)))
		begin
			@(posedge i_clk);
			waited++;
		end
		if (exp_q.size() != 0)
			stop_with_failure("results were still expected after the pipeline drained");
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		stop_with_failure("watchdog expired before the tests finished");
	end

	initial
	begin
		int n;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_sample = '0;
		i_wr_coeff = 1'b0;
		i_coeff = '0;
		void'($urandom(SEED));
		apply_reset;

		// Impulse after a run of zeros
		load_random_coeffs(NCOEFFS);
		for (n = 0; n < N_IMPULSE; n++)
			send_sample((n == NCOEFFS) ? IMPULSE : '0);
		drain_results;

		// Continuous random stream
		for (n = 0; n < N_STREAM; n++)
			send_sample(IW'($urandom));
		drain_results;

		// Random gaps in i_valid
		for (n = 0; n < N_BURST; n++)
		begin
			if (($urandom % 2) == 0)
				idle_cycles(int'(1 + $urandom % 3));
			send_sample(IW'($urandom));
		end
		drain_results;

		// Full scale taps against full scale blocks of either sign
		for (n = 0; n < NCOEFFS; n++)
			write_coeff(CMIN);
		i_wr_coeff <= 1'b0;
		for (n = 0; n < N_SAT; n++)
			send_sample((((n / SAT_BLOCK) % 2) == 0) ? SMAX : SMIN);
		drain_results;

		// Three extra writes land on taps 0 to 2
		apply_reset;
		load_random_coeffs(NCOEFFS + 3);
		for (n = 0; n < N_WRAP; n++)
		begin
			if (($urandom % 4) == 0)
				idle_cycles(int'(1 + $urandom % 2));
			send_sample(IW'($urandom));
		end
		drain_results;

		// Nothing more may come out
		idle_cycles(2 * LATENCY);
		check_value("result count", 32'(n_outputs), 32'(n_triggers));
		if ((NDOWN <= NCOEFFS) && (n_stalls == 0))
			stop_with_failure("no trigger sample was ever held off by o_ready");
		else if ((n_sat_hi == 0) || (n_sat_lo == 0))
			stop_with_failure("saturation did not reach both output limits");
		else
		begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
// Free running from time zero with no enable and no reset, the period must be an even number of ns
`default_nettype none
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic o_clk
);

	// Starts low so the first rising edge comes half a period in
	initial
		o_clk = 1'b0;

	always
		#(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

//--- hw/fildown_top.sv
// Output follows the trigger sample by NCOEFFS+4 clocks and there is no output back-pressure
`default_nettype none
`timescale 1ns/1ps

module fildown_top #(
	parameter int NDOWN = fildown_pkg::DEF_NDOWN,
	parameter int NCOEFFS = fildown_pkg::DEF_NCOEFFS,
	parameter int SHIFT = fildown_pkg::DEF_SHIFT
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_valid,
	input wire [fildown_pkg::IW-1:0] i_sample,
	output logic o_ready,
	input wire i_wr_coeff,
	input wire [fildown_pkg::CW-1:0] i_coeff,
	output logic o_valid,
	output logic [fildown_pkg::OW-1:0] o_result
);
	import fildown_pkg::*;

	// Same derivations as in the stages
	localparam int TW = (NCOEFFS > 1) ? $clog2(NCOEFFS) : 1;
	localparam int WW = $clog2(NCOEFFS + NDOWN - 1);
	localparam int AW = IW + CW + TW;

	// Window to sequencer
	logic trigger;
	logic [WW-1:0] trig_addr;
	logic busy;
	// Read addresses and data
	logic [TW-1:0] tap;
	logic [WW-1:0] rd_addr;
	logic [IW-1:0] sample;
	logic [CW-1:0] coeff;
	// Run marks lined up with the products
	logic first;
	logic last;
	// Finished sum
	logic [AW-1:0] acc;
	logic acc_done;

	sample_window #(.NDOWN(NDOWN), .NCOEFFS(NCOEFFS)) sample_window_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid(i_valid), .i_sample(i_sample), .o_ready(o_ready),
		.i_busy(busy), .i_rd_addr(rd_addr), .o_sample(sample),
		.o_trigger(trigger), .o_trig_addr(trig_addr)
	);

	coeff_store #(.NCOEFFS(NCOEFFS)) coeff_store_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wr_coeff(i_wr_coeff), .i_coeff(i_coeff),
		.i_tap(tap), .o_coeff(coeff)
	);

	tap_sequencer #(.NCOEFFS(NCOEFFS), .NDOWN(NDOWN)) tap_sequencer_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_trigger(trigger), .i_trig_addr(trig_addr),
		.o_tap(tap), .o_rd_addr(rd_addr), .o_busy(busy),
		.o_first(first), .o_last(last)
	);

	mac_stage #(.NCOEFFS(NCOEFFS)) mac_stage_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_sample(sample), .i_coeff(coeff),
		.i_first(first), .i_last(last),
		.o_acc(acc), .o_acc_done(acc_done)
	);

	round_saturate #(.NCOEFFS(NCOEFFS), .SHIFT(SHIFT)) round_saturate_inst (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_acc(acc), .i_acc_done(acc_done),
		.o_valid(o_valid), .o_result(o_result)
	);

endmodule

`default_nettype wire

//--- hw/round_saturate.sv
// Needs the accumulator to be at least OW+SHIFT+2 bits wide so two or more bits get rounded off
`default_nettype none
`timescale 1ns/1ps

module round_saturate #(
	parameter int NCOEFFS = fildown_pkg::DEF_NCOEFFS,
	parameter int SHIFT = fildown_pkg::DEF_SHIFT,
	localparam int TW = (NCOEFFS > 1) ? $clog2(NCOEFFS) : 1,
	localparam int AW = fildown_pkg::IW + fildown_pkg::CW + TW
) (
	input wire i_clk,
	input wire i_reset,
	input wire [AW-1:0] i_acc,
	input wire i_acc_done,
	output logic o_valid,
	output logic [fildown_pkg::OW-1:0] o_result
);
	import fildown_pkg::*;

	// Bits below the output LSB after the gain shift
	localparam int FRAC = AW - SHIFT - OW;
	// Extra sign, dropped gain bits and the output word
	localparam int UW = OW + SHIFT + 1;

	logic sign;
	logic round_up;
	logic [UW-1:0] upper;
	logic overflow;

	assign sign = i_acc[AW-1];
	// Round half to even, ties go up only when the kept LSB is odd
	assign round_up = i_acc[FRAC-1] && (i_acc[FRAC] || (|i_acc[FRAC-2:0]));
	assign upper = {sign, i_acc[AW-1:FRAC]} + UW'(round_up);
	// Dropped bits and the new MSB must all agree, or the word does not fit
	// A rounding carry into the sign shows up here as well
	assign overflow = !(&upper[UW-1:OW-1]) && (|upper[UW-1:OW-1]);

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_result <= '0;
		end
		else
		begin
			o_valid <= i_acc_done;
			if (i_acc_done)
			begin
				// Saturate toward the accumulator sign
				if (overflow)
					o_result <= sign ? {1'b1, {(OW-1){1'b0}}}
						: {1'b0, {(OW-1){1'b1}}};
				else
					o_result <= upper[OW-1:0];
			end
		end
	end

	a_result_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		!o_valid |-> $stable(o_result));

endmodule

`default_nettype wire

//--- hw/mac_stage.sv
// One product per clock and the sum is only meaningful on the cycle o_acc_done is high
`default_nettype none
`timescale 1ns/1ps

module mac_stage #(
	parameter int NCOEFFS = fildown_pkg::DEF_NCOEFFS,
	localparam int TW = (NCOEFFS > 1) ? $clog2(NCOEFFS) : 1,
	localparam int AW = fildown_pkg::IW + fildown_pkg::CW + TW
) (
	input wire i_clk,
	input wire i_reset,
	input wire [fildown_pkg::IW-1:0] i_sample,
	input wire [fildown_pkg::CW-1:0] i_coeff,
	input wire i_first,
	input wire i_last,
	output logic [AW-1:0] o_acc,
	output logic o_acc_done
);
	import fildown_pkg::*;

	// Full precision product of the two read words
	logic signed [IW+CW-1:0] product;
	logic [AW-1:0] product_ext;
	// Between the first and last product of a run
	logic in_run;

	always_ff @(posedge i_clk)
		product <= $signed(i_sample) * $signed(i_coeff);

	// Guard bits cover the growth of NCOEFFS additions
	assign product_ext = {{TW{product[IW+CW-1]}}, product};

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			in_run <= 1'b0;
			o_acc_done <= 1'b0;
		end
		else
		begin
			if (i_first)
				in_run <= !i_last;
			else if (i_last)
				in_run <= 1'b0;
			// Sum is complete one cycle after the last product
			o_acc_done <= i_last;
		end
	end

	// First product restarts the sum, later ones add in
	always_ff @(posedge i_clk)
	begin
		if (i_first)
			o_acc <= product_ext;
		else if (in_run)
			o_acc <= o_acc + product_ext;
	end

endmodule

`default_nettype wire

//--- hw/tap_sequencer.sv
// A trigger is expected only while idle, which the window guarantees through o_ready
`default_nettype none
`timescale 1ns/1ps

module tap_sequencer #(
	parameter int NCOEFFS = fildown_pkg::DEF_NCOEFFS,
	parameter int NDOWN = fildown_pkg::DEF_NDOWN,
	localparam int TW = (NCOEFFS > 1) ? $clog2(NCOEFFS) : 1,
	localparam int WW = $clog2(NCOEFFS + NDOWN - 1)
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_trigger,
	input wire [WW-1:0] i_trig_addr,
	output logic [TW-1:0] o_tap,
	output logic [WW-1:0] o_rd_addr,
	output logic o_busy,
	output logic o_first,
	output logic o_last
);
	import fildown_pkg::*;

	logic issue_first;
	logic issue_last;
	// First stage of the two-cycle mark delay
	logic first_d;
	logic last_d;

	// Marks as the addresses go out
	assign issue_first = o_busy && (o_tap == '0);
	assign issue_last = o_busy && (o_tap == TW'(NCOEFFS - 1));

	////////////////////////////////////////////////////////////
	// Address walk, tap up and sample back in time
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_busy <= 1'b0;
			o_tap <= '0;
			o_rd_addr <= '0;
		end
		else if (i_trigger)
		begin
			o_busy <= 1'b1;
			o_tap <= '0;
			o_rd_addr <= i_trig_addr;
		end
		else if (issue_last)
			o_busy <= 1'b0;
		else if (o_busy)
		begin
			o_tap <= o_tap + 1'b1;
			o_rd_addr <= o_rd_addr - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Marks delayed past the memory read and the product register
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			first_d <= 1'b0;
			last_d <= 1'b0;
			o_first <= 1'b0;
			o_last <= 1'b0;
		end
		else
		begin
			first_d <= issue_first;
			last_d <= issue_last;
			o_first <= first_d;
			o_last <= last_d;
		end
	end

	// First and last mark of a run sit exactly NCOEFFS-1 products apart
	a_first_last: assert property (@(posedge i_clk) disable iff (i_reset)
		o_first |-> ((NCOEFFS == 1) || !o_last) ##(NCOEFFS - 1) o_last);

endmodule

`default_nettype wire

//--- hw/sample_window.sv
// Window memory is not cleared by reset and i_sample must hold steady while o_ready is low
`default_nettype none
`timescale 1ns/1ps

module sample_window #(
	parameter int NDOWN = fildown_pkg::DEF_NDOWN,
	parameter int NCOEFFS = fildown_pkg::DEF_NCOEFFS,
	localparam int WW = $clog2(NCOEFFS + NDOWN - 1),
	localparam int DW = (NDOWN > 1) ? $clog2(NDOWN) : 1
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_valid,
	input wire [fildown_pkg::IW-1:0] i_sample,
	output logic o_ready,
	input wire i_busy,
	input wire [WW-1:0] i_rd_addr,
	output logic [fildown_pkg::IW-1:0] o_sample,
	output logic o_trigger,
	output logic [WW-1:0] o_trig_addr
);
	import fildown_pkg::*;

	// Circular history, deep enough that samples taken in during a run
	// never land on samples that run still reads
	logic [IW-1:0] mem [0:(1 << WW)-1];
	logic [WW-1:0] wr_ptr;
	// Counts down to the trigger sample of each group
	logic [DW-1:0] count;
	logic at_trigger;
	logic accept;

	assign at_trigger = (count == '0);
	// Stall only a trigger sample while the sequencer is still walking taps
	assign o_ready = !(i_busy && at_trigger);
	assign accept = i_valid && o_ready;
	assign o_trigger = accept && at_trigger;
	// Trigger sample lands here on this edge
	assign o_trig_addr = wr_ptr;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			count <= DW'(NDOWN - 1);
		end
		else if (accept)
		begin
			wr_ptr <= wr_ptr + 1'b1;
			if (at_trigger)
				count <= DW'(NDOWN - 1);
			else
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
			mem[wr_ptr] <= i_sample;
	end

	// Registered read for the MAC
	always_ff @(posedge i_clk)
		o_sample <= mem[i_rd_addr];

	// Trigger is taken only when idle, and the sequencer goes busy right after
	a_trigger_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		o_trigger |-> !i_busy ##1 i_busy);

endmodule

`default_nettype wire

//--- hw/coeff_store.sv
// Taps load in order from reset and writes during a run corrupt that run's result
`default_nettype none
`timescale 1ns/1ps

module coeff_store #(
	parameter int NCOEFFS = fildown_pkg::DEF_NCOEFFS,
	localparam int TW = (NCOEFFS > 1) ? $clog2(NCOEFFS) : 1
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_wr_coeff,
	input wire [fildown_pkg::CW-1:0] i_coeff,
	input wire [TW-1:0] i_tap,
	output logic [fildown_pkg::CW-1:0] o_coeff
);
	import fildown_pkg::*;

	// One word per tap
	logic [CW-1:0] mem [0:NCOEFFS-1];
	// Next tap to be written
	logic [TW-1:0] wr_ptr;

	// Pointer wraps, so extra writes replace the earliest taps
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_ptr <= '0;
		else if (i_wr_coeff)
		begin
			if (wr_ptr == TW'(NCOEFFS - 1))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_wr_coeff)
			mem[wr_ptr] <= i_coeff;
	end

	// Registered read, coefficient lags the tap address by one cycle
	always_ff @(posedge i_clk)
		o_coeff <= mem[i_tap];

	a_wr_ptr_range: assert property (@(posedge i_clk) disable iff (i_reset)
		int'(wr_ptr) < NCOEFFS);

endmodule

`default_nettype wire

//--- hw/fildown_pkg.sv
// Widths are fixed for every build and the accumulator must exceed OW+SHIFT by two bits or more
`default_nettype none

package fildown_pkg;

	////////////////////////////////////////////////////////////
	// Data path widths
	////////////////////////////////////////////////////////////

	// Signed input sample
	localparam int IW = 16;
	// Signed filter coefficient
	localparam int CW = 12;
	// Signed output word after rounding
	localparam int OW = 24;

	////////////////////////////////////////////////////////////
	// Default filter shape, overridden from the top level
	////////////////////////////////////////////////////////////

	// One output for every DEF_NDOWN accepted samples
	localparam int DEF_NDOWN = 5;
	// Number of taps held in the coefficient store
	localparam int DEF_NCOEFFS = 16;
	// Gain shift applied before rounding
	localparam int DEF_SHIFT = 2;

endpackage

`default_nettype wire
